// ==== src/hist_pkg.sv ====
package hist_pkg;

    // timestamp and window start width
    localparam int TIME_BITS = 12;

    // histogram geometry
    localparam int BIN_BITS = 4;
    localparam int BIN_NUM = 16;
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_BITS = 2;
    localparam int DATA_NUM = 2;
    localparam int ACQ_NUM = 3;

    // max bin value is DATA_NUM * ACQ_NUM, well inside 8 bits
    localparam int COUNT_BITS = 8;

    // bin resolution, timestamp lsbs dropped per mode
    localparam int FINE_SHIFT = 0;
    localparam int COARSE_SHIFT = 4;

    // frame counter widths
    localparam int DATA_BITS = 1;
    localparam int ACQ_BITS = 2;

    // one bank, pixel-major with bin fastest
    localparam int HIST_SIZE = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_BITS = PIXEL_BITS + BIN_BITS;

    // terminal counts
    localparam logic [DATA_BITS-1:0] DATA_LAST = DATA_BITS'(DATA_NUM - 1);
    localparam logic [PIXEL_BITS-1:0] PIXEL_LAST = PIXEL_BITS'(PIXEL_NUM - 1);
    localparam logic [ACQ_BITS-1:0] ACQ_LAST = ACQ_BITS'(ACQ_NUM - 1);
    localparam logic [BIN_BITS-1:0] BIN_LAST = BIN_BITS'(BIN_NUM - 1);
    localparam logic [ADDR_BITS-1:0] HIST_LAST = ADDR_BITS'(HIST_SIZE - 1);

    // control FSM states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ACCUM = 2'd1,
        ST_HOLD  = 2'd2,
        ST_SWAP  = 2'd3
    } hist_state_t;

endpackage

// ==== src/hist_mem_if.sv ====
interface hist_mem_if;

    // write strobe for one hit
    logic hit_en;
    // pixel of that hit, from the frame counters
    logic [hist_pkg::PIXEL_BITS-1:0] pixel;
    // bin of that hit, from the mapper
    logic [hist_pkg::BIN_BITS-1:0] bin;
    // bank being accumulated
    logic bank_sel;
    // single cycle, banks exchange roles
    logic swap;

    modport ctrl (
        output hit_en,
        output pixel,
        output bank_sel,
        output swap
    );

    modport mapper (
        output bin
    );

    modport bank (
        input hit_en,
        input pixel,
        input bin,
        input bank_sel,
        input swap
    );

endinterface

// ==== src/hist_ctrl.sv ====
module hist_ctrl (
    input  logic clk,
    input  logic combin_res,
    input  logic mapped_valid,
    input  logic readout_busy,
    hist_mem_if.ctrl mem,
    output logic readout_start,
    output logic frame_done,
    output logic hist_num,
    output logic overrun
);

    hist_pkg::hist_state_t state;
    hist_pkg::hist_state_t state_next;

    // nested frame counters: hits, then pixels, then acquisitions
    logic [hist_pkg::DATA_BITS-1:0] hit_cnt;
    logic [hist_pkg::PIXEL_BITS-1:0] pixel_cnt;
    logic [hist_pkg::ACQ_BITS-1:0] acq_cnt;

    logic hit_last;
    logic pixel_last;
    logic acq_last;
    logic frame_last;
    logic enter_swap;
    logic bank_sel;

    // mapped hits are dropped while the frame waits in hold
    assign mem.hit_en = mapped_valid && (state != hist_pkg::ST_HOLD);
    assign mem.pixel = pixel_cnt;
    assign mem.bank_sel = bank_sel;

    assign hit_last = (hit_cnt == hist_pkg::DATA_LAST);
    assign pixel_last = (pixel_cnt == hist_pkg::PIXEL_LAST);
    assign acq_last = (acq_cnt == hist_pkg::ACQ_LAST);
    // write of the last hit of the frame
    assign frame_last = mem.hit_en && hit_last && pixel_last && acq_last;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt <= '0;
        end else if (mem.hit_en) begin
            // counters wrap to zero on the last hit, ready for next frame
            if (hit_last) begin
                hit_cnt <= '0;
                if (pixel_last) begin
                    pixel_cnt <= '0;
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                hit_cnt <= hit_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            hist_pkg::ST_IDLE, hist_pkg::ST_ACCUM, hist_pkg::ST_SWAP: begin
                if (frame_last) begin
                    // finished bank may only swap in when readout is free
                    state_next = readout_busy ? hist_pkg::ST_HOLD : hist_pkg::ST_SWAP;
                end else if (mem.hit_en) begin
                    state_next = hist_pkg::ST_ACCUM;
                end else if (state == hist_pkg::ST_SWAP) begin
                    state_next = hist_pkg::ST_IDLE;
                end
            end
            hist_pkg::ST_HOLD: begin
                if (!readout_busy) begin
                    state_next = hist_pkg::ST_SWAP;
                end
            end
            default: state_next = hist_pkg::ST_IDLE;
        endcase
    end

    // bank_sel flips on entry so a hit in the swap cycle already
    // lands in the new bank
    assign enter_swap = (state_next == hist_pkg::ST_SWAP) && (state != hist_pkg::ST_SWAP);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= hist_pkg::ST_IDLE;
            bank_sel <= 1'b0;
            hist_num <= 1'b0;
            overrun <= 1'b0;
        end else begin
            state <= state_next;
            if (enter_swap) begin
                bank_sel <= ~bank_sel;
                hist_num <= ~hist_num;
            end
            // sticky until reset
            if (state_next == hist_pkg::ST_HOLD) begin
                overrun <= 1'b1;
            end
        end
    end

    // swap cycle strobes
    assign mem.swap = (state == hist_pkg::ST_SWAP);
    assign readout_start = (state == hist_pkg::ST_SWAP);
    assign frame_done = (state == hist_pkg::ST_SWAP);

endmodule

// ==== src/bin_mapper.sv ====
module bin_mapper (
    input  logic clk,
    input  logic combin_res,
    input  logic hit_valid,
    input  logic [hist_pkg::TIME_BITS-1:0] hit_time,
    input  logic [hist_pkg::TIME_BITS-1:0] window_start,
    input  logic fine_mode,
    hist_mem_if.mapper mem,
    output logic mapped_valid
);

    // one extra bit to catch a hit before the window
    logic [hist_pkg::TIME_BITS:0] diff;
    logic [hist_pkg::TIME_BITS-1:0] shifted;
    logic [hist_pkg::BIN_BITS-1:0] bin_calc;
    logic [hist_pkg::BIN_BITS-1:0] bin_q;

    always_comb begin
        diff = {1'b0, hit_time} - {1'b0, window_start};
        if (fine_mode) begin
            shifted = diff[hist_pkg::TIME_BITS-1:0] >> hist_pkg::FINE_SHIFT;
        end else begin
            shifted = diff[hist_pkg::TIME_BITS-1:0] >> hist_pkg::COARSE_SHIFT;
        end
        // borrow set, hit came early
        if (diff[hist_pkg::TIME_BITS]) begin
            bin_calc = '0;
        end else if (|shifted[hist_pkg::TIME_BITS-1:hist_pkg::BIN_BITS]) begin
            // past the last bin
            bin_calc = hist_pkg::BIN_LAST;
        end else begin
            bin_calc = shifted[hist_pkg::BIN_BITS-1:0];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            mapped_valid <= 1'b0;
        end else begin
            mapped_valid <= hit_valid;
        end
    end

    // bin only loads with a hit
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            bin_q <= bin_calc;
        end
    end

    assign mem.bin = bin_q;

endmodule

// ==== src/hist_bank.sv ====
module hist_bank (
    input  logic clk,
    input  logic combin_res,
    hist_mem_if.bank mem,
    input  logic [hist_pkg::PIXEL_BITS-1:0] rd_pixel,
    input  logic [hist_pkg::BIN_BITS-1:0] rd_bin,
    output logic [hist_pkg::COUNT_BITS-1:0] rd_count
);

    // bin counters, two banks
    logic [hist_pkg::COUNT_BITS-1:0] count_mem [2][hist_pkg::HIST_SIZE];
    // written bitmap per bank, a clear bit means the counter is stale
    logic [hist_pkg::HIST_SIZE-1:0] written [2];

    logic [hist_pkg::ADDR_BITS-1:0] wr_addr;
    logic [hist_pkg::ADDR_BITS-1:0] rd_addr;
    logic rd_bank;
    logic wr_seen;
    logic [hist_pkg::COUNT_BITS-1:0] wr_old;
    logic [hist_pkg::COUNT_BITS-1:0] wr_next;

    // pixel-major layout
    assign wr_addr = {mem.pixel, mem.bin};
    assign rd_addr = {rd_pixel, rd_bin};

    // readout always looks at the bank not being written
    assign rd_bank = ~mem.bank_sel;

    // a hit in the swap cycle sees the bitmap as already cleared
    assign wr_seen = written[mem.bank_sel][wr_addr] && !mem.swap;
    assign wr_old = count_mem[mem.bank_sel][wr_addr];

    always_comb begin
        if (wr_seen) begin
            wr_next = wr_old + 1'b1;
        end else begin
            // first hit in this bin since the bank went active
            wr_next = {{(hist_pkg::COUNT_BITS-1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            written[0] <= '0;
            written[1] <= '0;
        end else begin
            // wipe the whole map of the newly active bank at once
            if (mem.swap) begin
                written[mem.bank_sel] <= '0;
            end
            // later assignment wins, the hit's bit survives the wipe
            if (mem.hit_en) begin
                written[mem.bank_sel][wr_addr] <= 1'b1;
            end
        end
    end

    // single cycle read-modify-write
    always_ff @(posedge clk) begin
        if (mem.hit_en) begin
            count_mem[mem.bank_sel][wr_addr] <= wr_next;
        end
    end

    // registered read, stale bins read as zero
    always_ff @(posedge clk) begin
        if (written[rd_bank][rd_addr]) begin
            rd_count <= count_mem[rd_bank][rd_addr];
        end else begin
            rd_count <= '0;
        end
    end

endmodule

// ==== src/hist_readout.sv ====
module hist_readout (
    input  logic clk,
    input  logic combin_res,
    input  logic readout_start,
    output logic [hist_pkg::PIXEL_BITS-1:0] rd_pixel,
    output logic [hist_pkg::BIN_BITS-1:0] rd_bin,
    input  logic [hist_pkg::COUNT_BITS-1:0] rd_count,
    output logic readout_busy,
    output logic rd_valid,
    output logic [hist_pkg::PIXEL_BITS-1:0] out_pixel,
    output logic [hist_pkg::BIN_BITS-1:0] out_bin,
    output logic [hist_pkg::COUNT_BITS-1:0] out_count
);

    logic scan_active;
    // address being read this cycle
    logic [hist_pkg::ADDR_BITS-1:0] scan_addr;
    // address of the count coming back from the bank
    logic [hist_pkg::ADDR_BITS-1:0] out_addr;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            scan_active <= 1'b0;
            scan_addr <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (readout_start) begin
                scan_active <= 1'b1;
                scan_addr <= '0;
            end else if (scan_active) begin
                // one pass, stop after the last bin of the last pixel
                if (scan_addr == hist_pkg::HIST_LAST) begin
                    scan_active <= 1'b0;
                end
                scan_addr <= scan_addr + 1'b1;
            end
            // data follows the address by one cycle
            rd_valid <= scan_active;
        end
    end

    // align the beat's address with the registered count
    always_ff @(posedge clk) begin
        out_addr <= scan_addr;
    end

    assign rd_pixel = scan_addr[hist_pkg::ADDR_BITS-1:hist_pkg::BIN_BITS];
    assign rd_bin = scan_addr[hist_pkg::BIN_BITS-1:0];

    assign out_pixel = out_addr[hist_pkg::ADDR_BITS-1:hist_pkg::BIN_BITS];
    assign out_bin = out_addr[hist_pkg::BIN_BITS-1:0];
    assign out_count = rd_count;

    // busy through the last beat
    assign readout_busy = scan_active | rd_valid;

endmodule

// ==== src/hist_builder_top.sv ====
module hist_builder_top (
    input  logic clk,
    input  logic combin_res,
    input  logic hit_valid,
    input  logic [hist_pkg::TIME_BITS-1:0] hit_time,
    input  logic [hist_pkg::TIME_BITS-1:0] window_start,
    input  logic fine_mode,
    output logic rd_valid,
    output logic [hist_pkg::PIXEL_BITS-1:0] out_pixel,
    output logic [hist_pkg::BIN_BITS-1:0] out_bin,
    output logic [hist_pkg::COUNT_BITS-1:0] out_count,
    output logic frame_done,
    output logic hist_num,
    output logic overrun
);

    // mapper to control
    logic mapped_valid;

    // readout handshake with control
    logic readout_start;
    logic readout_busy;

    // bank read port
    logic [hist_pkg::PIXEL_BITS-1:0] rd_pixel;
    logic [hist_pkg::BIN_BITS-1:0] rd_bin;
    logic [hist_pkg::COUNT_BITS-1:0] rd_count;

    // write path, control and mapper into the banks
    hist_mem_if mem_if ();

    hist_ctrl ctrl_i (
        .clk           (clk),
        .combin_res    (combin_res),
        .mapped_valid  (mapped_valid),
        .readout_busy  (readout_busy),
        .mem           (mem_if.ctrl),
        .readout_start (readout_start),
        .frame_done    (frame_done),
        .hist_num      (hist_num),
        .overrun       (overrun)
    );

    bin_mapper mapper_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .hit_valid    (hit_valid),
        .hit_time     (hit_time),
        .window_start (window_start),
        .fine_mode    (fine_mode),
        .mem          (mem_if.mapper),
        .mapped_valid (mapped_valid)
    );

    hist_bank bank_i (
        .clk        (clk),
        .combin_res (combin_res),
        .mem        (mem_if.bank),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count)
    );

    hist_readout readout_i (
        .clk           (clk),
        .combin_res    (combin_res),
        .readout_start (readout_start),
        .rd_pixel      (rd_pixel),
        .rd_bin        (rd_bin),
        .rd_count      (rd_count),
        .readout_busy  (readout_busy),
        .rd_valid      (rd_valid),
        .out_pixel     (out_pixel),
        .out_bin       (out_bin),
        .out_count     (out_count)
    );

endmodule

// ==== sim/hist_properties.sv ====
module hist_properties (
    input logic clk,
    input logic combin_res,
    input logic frame_done,
    input logic in_hold,
    input logic [hist_pkg::ACQ_BITS+hist_pkg::PIXEL_BITS+hist_pkg::DATA_BITS-1:0] frame_pos,
    input logic overrun,
    input logic readout_start,
    input logic rd_valid
);

    // failed assertions seen in this instance
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // swap strobe is a single cycle
    a_frame_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done)
        else begin
            $error("frame_done held for more than one cycle");
            fail_count++;
        end

    // held frame is complete, no hit counted since
    a_no_write_in_hold: assert property (@(posedge clk) disable iff (!combin_res)
        in_hold |-> (frame_pos == '0))
        else begin
            $error("frame counters moved while the frame was held");
            fail_count++;
        end

    // start, one address cycle, then 64 contiguous beats
    a_readout_len: assert property (@(posedge clk) disable iff (!combin_res)
        readout_start |=> ##1 rd_valid [*64] ##1 !rd_valid)
        else begin
            $error("rd_valid not high for exactly 64 cycles");
            fail_count++;
        end

    // sticky until reset
    a_overrun_sticky: assert property (@(posedge clk) disable iff (!combin_res)
        overrun |=> overrun)
        else begin
            $error("overrun fell without reset");
            fail_count++;
        end

endmodule

// readout ports tied low here, their check idles in this instance
bind hist_ctrl hist_properties ctrl_props_i (
    .clk           (clk),
    .combin_res    (combin_res),
    .frame_done    (frame_done),
    .in_hold       (state == hist_pkg::ST_HOLD),
    .frame_pos     ({acq_cnt, pixel_cnt, hit_cnt}),
    .overrun       (overrun),
    .readout_start (1'b0),
    .rd_valid      (1'b0)
);

bind hist_readout hist_properties readout_props_i (
    .clk           (clk),
    .combin_res    (combin_res),
    .frame_done    (1'b0),
    .in_hold       (1'b0),
    .frame_pos     ('0),
    .overrun       (1'b0),
    .readout_start (readout_start),
    .rd_valid      (rd_valid)
);

// ==== sim/hist_builder_tb.sv ====
module hist_builder_tb;

    localparam int FRAME_HITS = hist_pkg::DATA_NUM * hist_pkg::PIXEL_NUM * hist_pkg::ACQ_NUM;
    localparam int FRAME_TOTAL = 6;

    typedef logic [FRAME_HITS-1:0][hist_pkg::TIME_BITS-1:0] hit_list_t;
    typedef logic [hist_pkg::HIST_SIZE-1:0][hist_pkg::COUNT_BITS-1:0] image_t;

    logic clk;
    logic combin_res;
    logic hit_valid;
    logic [hist_pkg::TIME_BITS-1:0] hit_time;
    logic [hist_pkg::TIME_BITS-1:0] window_start;
    logic fine_mode;
    logic rd_valid;
    logic [hist_pkg::PIXEL_BITS-1:0] out_pixel;
    logic [hist_pkg::BIN_BITS-1:0] out_bin;
    logic [hist_pkg::COUNT_BITS-1:0] out_count;
    logic frame_done;
    logic hist_num;
    logic overrun;

    logic [31:0] lcg_state;
    // expected images, one per frame_done in order
    image_t exp_q[$];
    int frames_checked;
    int err_count;
    int check_count;
    int test_fail;
    bit timed_out;

    hist_builder_top dut_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .hit_valid    (hit_valid),
        .hit_time     (hit_time),
        .window_start (window_start),
        .fine_mode    (fine_mode),
        .rd_valid     (rd_valid),
        .out_pixel    (out_pixel),
        .out_bin      (out_bin),
        .out_count    (out_count),
        .frame_done   (frame_done),
        .hist_num     (hist_num),
        .overrun      (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // lcg, upper bits of the state
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:16];
    endfunction

    function automatic hit_list_t random_hits(input int base, input int span);
        hit_list_t hits;
        for (int k = 0; k < FRAME_HITS; k++) begin
            hits[k] = hist_pkg::TIME_BITS'(base + int'(lcg_next() % span));
        end
        return hits;
    endfunction

    // expected image: hit k goes to pixel (k / DATA_NUM) mod PIXEL_NUM
    function automatic image_t ref_image(input hit_list_t hits, input int ws, input bit fine);
        image_t img;
        int diff;
        int slot;
        int idx;
        img = '0;
        for (int k = 0; k < FRAME_HITS; k++) begin
            diff = int'(hits[k]) - ws;
            if (diff < 0) begin
                slot = 0;
            end else begin
                slot = diff >> (fine ? hist_pkg::FINE_SHIFT : hist_pkg::COARSE_SHIFT);
                if (slot >= hist_pkg::BIN_NUM) begin
                    slot = hist_pkg::BIN_NUM - 1;
                end
            end
            idx = ((k / hist_pkg::DATA_NUM) % hist_pkg::PIXEL_NUM) * hist_pkg::BIN_NUM + slot;
            img[idx] = img[idx] + 1'b1;
        end
        return img;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, sig, exp, got);
            err_count++;
        end
    endtask

    // one hit per cycle, then hit_valid drops
    task automatic send_frame(input hit_list_t hits, input int ws, input bit fine);
        exp_q.push_back(ref_image(hits, ws, fine));
        for (int k = 0; k < FRAME_HITS; k++) begin
            @(posedge clk);
            #2;
            window_start = hist_pkg::TIME_BITS'(ws);
            fine_mode = fine;
            hit_valid = 1'b1;
            hit_time = hits[k];
        end
        @(posedge clk);
        #2;
        hit_valid = 1'b0;
    endtask

    task automatic wait_checked(input int target);
        int waited;
        waited = 0;
        while (frames_checked < target && waited < 1000 && !timed_out) begin
            @(negedge clk);
            waited++;
        end
        if (frames_checked < target && !timed_out) begin
            $display("timeout: readout of frame %0d never completed", target - 1);
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input int id, input string name, input int err_before);
        if (err_count != err_before || timed_out) begin
            test_fail++;
            $display("test %0d %s: FAILED, %0d errors", id, name, err_count - err_before);
        end else begin
            $display("test %0d %s: ok", id, name);
        end
    endtask

    // collects the 64 beats after each frame_done
    initial begin : compare_proc
        image_t exp_img;
        int waited;
        for (int f = 0; f < FRAME_TOTAL; f++) begin
            waited = 0;
            @(negedge clk);
            while (!frame_done && waited < 400) begin
                @(negedge clk);
                waited++;
            end
            if (!frame_done) begin
                $display("timeout: frame_done of frame %0d never came", f);
                timed_out = 1'b1;
                break;
            end
            // first frame_done sets hist_num
            check_value("hist_num", hist_num, (f % 2 == 0) ? 1 : 0);
            exp_img = '0;
            if (exp_q.size() == 0) begin
                $display("error: frame_done at %0t with no frame sent", $time);
                err_count++;
            end else begin
                exp_img = exp_q.pop_front();
            end
            for (int beat = 0; beat < hist_pkg::HIST_SIZE; beat++) begin
                waited = 0;
                @(negedge clk);
                // first beat may lag, later beats must be back to back
                while (!rd_valid && beat == 0 && waited < 4) begin
                    @(negedge clk);
                    waited++;
                end
                if (!rd_valid) begin
                    $display("readout stream of frame %0d stopped at beat %0d", f, beat);
                    timed_out = 1'b1;
                    break;
                end
                check_value("out_pixel", out_pixel, beat / hist_pkg::BIN_NUM);
                check_value("out_bin", out_bin, beat % hist_pkg::BIN_NUM);
                check_value("out_count", out_count, exp_img[beat]);
            end
            if (timed_out) begin
                break;
            end
            frames_checked++;
        end
    end

    initial begin : main_proc
        hit_list_t hits;
        hit_list_t hits_b;
        int err_before;
        int prop_fails;
        lcg_state = 32'd24122;
        combin_res = 1'b0;
        hit_valid = 1'b0;
        hit_time = '0;
        window_start = '0;
        fine_mode = 1'b1;
        frames_checked = 0;
        err_count = 0;
        check_count = 0;
        test_fail = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        combin_res = 1'b1;

        // reset values, then a fine frame straddling the window
        err_before = err_count;
        @(negedge clk);
        check_value("rd_valid", rd_valid, 0);
        check_value("frame_done", frame_done, 0);
        check_value("overrun", overrun, 0);
        check_value("hist_num", hist_num, 0);
        send_frame(random_hits(198, 20), 200, 1'b1);
        wait_checked(1);
        end_test(1, "fine frame", err_before);

        err_before = err_count;
        send_frame(random_hits(1000, 300), 1000, 1'b0);
        wait_checked(2);
        end_test(2, "coarse frame", err_before);

        // even hits early, odd hits far past the window
        err_before = err_count;
        for (int k = 0; k < FRAME_HITS; k++) begin
            if (k % 2 == 0) begin
                hits[k] = hist_pkg::TIME_BITS'(2000 - 1 - int'(lcg_next() % 500));
            end else begin
                hits[k] = hist_pkg::TIME_BITS'(2000 + 16 + int'(lcg_next() % 1500));
            end
        end
        send_frame(hits, 2000, 1'b1);
        wait_checked(3);
        end_test(3, "clamping", err_before);

        // bank last filled by the coarse frame, only bin 5 is hit now
        err_before = err_count;
        for (int k = 0; k < FRAME_HITS; k++) begin
            hits[k] = hist_pkg::TIME_BITS'(305);
        end
        send_frame(hits, 300, 1'b1);
        wait_checked(4);
        end_test(4, "lazy clear", err_before);

        // second frame completes during the first readout
        err_before = err_count;
        check_value("overrun", overrun, 0);
        hits = random_hits(40, 30);
        hits_b = random_hits(40, 30);
        send_frame(hits, 50, 1'b1);
        send_frame(hits_b, 50, 1'b1);
        wait_checked(6);
        check_value("overrun", overrun, 1);
        repeat (5) @(negedge clk);
        check_value("overrun", overrun, 1);
        end_test(5, "overrun", err_before);

        prop_fails = dut_i.ctrl_i.ctrl_props_i.fail_count
                   + dut_i.readout_i.readout_props_i.fail_count;
        $display("tests 5, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_fail, check_count, err_count, prop_fails);
        if (test_fail == 0 && err_count == 0 && prop_fails == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/hist_pkg.sv
src/hist_mem_if.sv
src/hist_ctrl.sv
src/bin_mapper.sv
src/hist_bank.sv
src/hist_readout.sv
src/hist_builder_top.sv
sim/hist_properties.sv
sim/hist_builder_tb.sv
